/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

    localparam int REG_W     = 32;
    localparam int DREG_W    = 64;  // hi/lo pair, product
    localparam int REGADDR_W = 5;
    localparam int SHAMT_W   = 5;
    localparam int CLZ_W     = 6;   // counts up to 32

    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        // immediate forms arrive here too, imm sits in reg2
        OP_TEQ,
        OP_TNE,
        OP_TGE,
        OP_TGEU,
        OP_TLT,
        OP_TLTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MOVZ,
        OP_MOVN,
        OP_SEB,
        OP_SEH,
        OP_MULT,
        OP_MULTU,
        OP_MUL,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_MOVE,
        SEL_ARITH,
        SEL_MUL,
        SEL_JUMP
    } alusel_e;

    typedef enum logic {
        PH_ISSUE,
        PH_FINISH
    } mult_phase_e;

endpackage

`default_nettype wire

/* ex_count_lead.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_count_lead (
    input  logic [ex_pkg::REG_W-1:0] word_i,
    input  logic                     ones_i,
    output logic [ex_pkg::CLZ_W-1:0] count_o
);

    logic [ex_pkg::REG_W-1:0] scan;

    // clo counts zeros of the inverted word
    assign scan = ones_i ? ~word_i : word_i;

    always_comb begin
        count_o = ex_pkg::CLZ_W'(ex_pkg::REG_W);   // no bit set
        // walk upward, highest set bit wins
        for (int i = 0; i < ex_pkg::REG_W; i++) begin
            if (scan[i]) begin
                count_o = ex_pkg::CLZ_W'(ex_pkg::REG_W - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

/* ex_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  ex_pkg::aluop_e             aluop_i,
    input  logic [ex_pkg::REG_W-1:0]   reg1_i,
    input  logic [ex_pkg::REG_W-1:0]   reg2_i,
    output logic [ex_pkg::REG_W-1:0]   logic_res_o,
    output logic [ex_pkg::REG_W-1:0]   shift_res_o,
    output logic [ex_pkg::REG_W-1:0]   arith_res_o,
    output logic                       ov_o,
    output logic                       trap_o
);

    localparam int MSB = ex_pkg::REG_W - 1;

    logic                       sub_op;
    logic [ex_pkg::REG_W-1:0]   reg2_mux;
    logic [ex_pkg::REG_W-1:0]   sum;
    logic                       ov_sum;
    logic                       lt_s;
    logic                       lt_u;
    logic [ex_pkg::SHAMT_W-1:0] shamt;
    logic [ex_pkg::CLZ_W-1:0]   lead_cnt;

    // signed compares reuse the subtractor
    assign sub_op = (aluop_i == ex_pkg::OP_SUB) || (aluop_i == ex_pkg::OP_SUBU) ||
                    (aluop_i == ex_pkg::OP_SLT) || (aluop_i == ex_pkg::OP_TLT) ||
                    (aluop_i == ex_pkg::OP_TGE);

    assign reg2_mux = sub_op ? (~reg2_i + ex_pkg::REG_W'(1)) : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // like signs in, other sign out
    assign ov_sum = (reg1_i[MSB] == (reg2_i[MSB] ^ sub_op)) && (sum[MSB] != reg1_i[MSB]);

    // sign of the difference decides when the signs agree
    assign lt_s = (reg1_i[MSB] && !reg2_i[MSB]) ||
                  ((reg1_i[MSB] == reg2_i[MSB]) && sum[MSB]);
    assign lt_u = reg1_i < reg2_i;

    assign shamt = reg1_i[ex_pkg::SHAMT_W-1:0];

    ex_count_lead u_count_lead (
        .word_i  (reg1_i),
        .ones_i  (aluop_i == ex_pkg::OP_CLO),
        .count_o (lead_cnt)
    );

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_AND: logic_res_o = reg1_i & reg2_i;
            ex_pkg::OP_OR:  logic_res_o = reg1_i | reg2_i;
            ex_pkg::OP_XOR: logic_res_o = reg1_i ^ reg2_i;
            ex_pkg::OP_NOR: logic_res_o = ~(reg1_i | reg2_i);
            default:        logic_res_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_SLL: shift_res_o = reg2_i << shamt;
            ex_pkg::OP_SRL: shift_res_o = reg2_i >> shamt;
            ex_pkg::OP_SRA: shift_res_o = $signed(reg2_i) >>> shamt;  // sign fill
            default:        shift_res_o = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_SLT: begin
                arith_res_o = {{MSB{1'b0}}, lt_s};
            end
            ex_pkg::OP_SLTU: begin
                arith_res_o = {{MSB{1'b0}}, lt_u};
            end
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                arith_res_o = sum;
            end
            ex_pkg::OP_CLZ, ex_pkg::OP_CLO: begin
                arith_res_o = {{(ex_pkg::REG_W - ex_pkg::CLZ_W){1'b0}}, lead_cnt};
            end
            default: begin
                arith_res_o = '0;
            end
        endcase
    end

    // only the trapping add/sub flag overflow
    assign ov_o = ((aluop_i == ex_pkg::OP_ADD) || (aluop_i == ex_pkg::OP_SUB)) && ov_sum;

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_TEQ:  trap_o = (reg1_i == reg2_i);
            ex_pkg::OP_TNE:  trap_o = (reg1_i != reg2_i);
            ex_pkg::OP_TGE:  trap_o = !lt_s;
            ex_pkg::OP_TGEU: trap_o = !lt_u;
            ex_pkg::OP_TLT:  trap_o = lt_s;
            ex_pkg::OP_TLTU: trap_o = lt_u;
            default:         trap_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* ex_mult.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mult (
    input  logic                      clk,
    input  logic                      rst,
    input  ex_pkg::aluop_e            aluop_i,
    input  logic [ex_pkg::REG_W-1:0]  reg1_i,
    input  logic [ex_pkg::REG_W-1:0]  reg2_i,
    input  logic [ex_pkg::REG_W-1:0]  hi_fwd_i,
    input  logic [ex_pkg::REG_W-1:0]  lo_fwd_i,
    output logic [ex_pkg::DREG_W-1:0] prod_o,
    output logic                      prod_valid_o,
    output logic                      stallreq_o
);

    localparam int MSB = ex_pkg::REG_W - 1;

    ex_pkg::mult_phase_e phase;

    logic is_mul;
    logic is_signed;
    logic is_acc;
    logic is_neg;

    logic signed [ex_pkg::REG_W:0]     op1;
    logic signed [ex_pkg::REG_W:0]     op2;
    logic signed [2*ex_pkg::REG_W+1:0] full;
    logic [ex_pkg::DREG_W-1:0]         raw;
    logic [ex_pkg::DREG_W-1:0]         issue_prod;
    logic [ex_pkg::DREG_W-1:0]         part;

    always_comb begin
        is_mul    = 1'b1;
        is_signed = 1'b0;
        is_acc    = 1'b0;
        is_neg    = 1'b0;
        case (aluop_i)
            ex_pkg::OP_MULT, ex_pkg::OP_MUL: is_signed = 1'b1;
            ex_pkg::OP_MULTU: ;
            ex_pkg::OP_MADD: begin
                is_signed = 1'b1;
                is_acc    = 1'b1;
            end
            ex_pkg::OP_MADDU: is_acc = 1'b1;
            ex_pkg::OP_MSUB: begin
                is_signed = 1'b1;
                is_acc    = 1'b1;
                is_neg    = 1'b1;
            end
            ex_pkg::OP_MSUBU: begin
                is_acc = 1'b1;
                is_neg = 1'b1;
            end
            default: is_mul = 1'b0;
        endcase
    end

    // one 33x33 signed multiplier covers both signed and unsigned
    assign op1 = {is_signed & reg1_i[MSB], reg1_i};
    assign op2 = {is_signed & reg2_i[MSB], reg2_i};
    assign full = op1 * op2;
    assign raw  = full[ex_pkg::DREG_W-1:0];

    assign issue_prod = is_neg ? (~raw + ex_pkg::DREG_W'(1)) : raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= ex_pkg::PH_ISSUE;
        end else if (phase == ex_pkg::PH_FINISH) begin
            phase <= ex_pkg::PH_ISSUE;
        end else if (is_mul) begin
            phase <= ex_pkg::PH_FINISH;
        end
    end

    always_ff @(posedge clk) begin
        if (is_mul && phase == ex_pkg::PH_ISSUE) begin
            part <= issue_prod;
        end
    end

    assign stallreq_o   = !rst && is_mul && (phase == ex_pkg::PH_ISSUE);
    assign prod_valid_o = (phase == ex_pkg::PH_FINISH);

    // accumulate against the forwarded hi/lo in the second cycle
    assign prod_o = !prod_valid_o ? '0 :
                    is_acc ? part + {hi_fwd_i, lo_fwd_i} : part;

endmodule

`default_nettype wire

/* ex_hilo.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_hilo (
    input  logic                      rst,
    input  ex_pkg::aluop_e            aluop_i,
    input  logic [ex_pkg::REG_W-1:0]  reg1_i,
    input  logic [ex_pkg::REG_W-1:0]  hi_i,
    input  logic [ex_pkg::REG_W-1:0]  lo_i,
    input  logic                      mem_whilo_i,
    input  logic [ex_pkg::REG_W-1:0]  mem_hi_i,
    input  logic [ex_pkg::REG_W-1:0]  mem_lo_i,
    input  logic                      wb_whilo_i,
    input  logic [ex_pkg::REG_W-1:0]  wb_hi_i,
    input  logic [ex_pkg::REG_W-1:0]  wb_lo_i,
    input  logic [ex_pkg::DREG_W-1:0] prod_i,
    input  logic                      prod_valid_i,
    output logic [ex_pkg::REG_W-1:0]  hi_fwd_o,
    output logic [ex_pkg::REG_W-1:0]  lo_fwd_o,
    output logic                      whilo_o,
    output logic [ex_pkg::REG_W-1:0]  hi_o,
    output logic [ex_pkg::REG_W-1:0]  lo_o
);

    logic we;

    // youngest write wins
    always_comb begin
        if (mem_whilo_i) begin
            {hi_fwd_o, lo_fwd_o} = {mem_hi_i, mem_lo_i};
        end else if (wb_whilo_i) begin
            {hi_fwd_o, lo_fwd_o} = {wb_hi_i, wb_lo_i};
        end else begin
            {hi_fwd_o, lo_fwd_o} = {hi_i, lo_i};
        end
    end

    always_comb begin
        we   = 1'b0;
        hi_o = '0;
        lo_o = '0;
        case (aluop_i)
            ex_pkg::OP_MTHI: begin
                we   = 1'b1;
                hi_o = reg1_i;
                lo_o = lo_fwd_o;
            end
            ex_pkg::OP_MTLO: begin
                we   = 1'b1;
                hi_o = hi_fwd_o;
                lo_o = reg1_i;
            end
            ex_pkg::OP_MULT, ex_pkg::OP_MULTU, ex_pkg::OP_MADD, ex_pkg::OP_MADDU,
            ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: begin
                we           = prod_valid_i;   // second cycle only
                {hi_o, lo_o} = prod_i;
            end
            default: ;
        endcase
    end

    assign whilo_o = we && !rst;

endmodule

`default_nettype wire

/* ex_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_writeback (
    input  logic                         rst,
    input  ex_pkg::aluop_e               aluop_i,
    input  ex_pkg::alusel_e              alusel_i,
    input  logic [ex_pkg::REG_W-1:0]     reg1_i,
    input  logic [ex_pkg::REG_W-1:0]     reg2_i,
    input  logic [ex_pkg::REGADDR_W-1:0] wd_i,
    input  logic                         wreg_i,
    input  logic [ex_pkg::REG_W-1:0]     link_address_i,
    input  logic [ex_pkg::REG_W-1:0]     logic_res_i,
    input  logic [ex_pkg::REG_W-1:0]     shift_res_i,
    input  logic [ex_pkg::REG_W-1:0]     arith_res_i,
    input  logic [ex_pkg::REG_W-1:0]     hi_fwd_i,
    input  logic [ex_pkg::REG_W-1:0]     lo_fwd_i,
    input  logic [ex_pkg::DREG_W-1:0]    prod_i,
    input  logic                         ov_i,
    input  logic                         trap_i,
    output logic [ex_pkg::REGADDR_W-1:0] wd_o,
    output logic                         wreg_o,
    output logic [ex_pkg::REG_W-1:0]     wdata_o,
    output logic                         except_trap_o,
    output logic                         except_ov_o
);

    logic [ex_pkg::REG_W-1:0] move_res;

    always_comb begin
        case (aluop_i)
            ex_pkg::OP_MFHI: move_res = hi_fwd_i;
            ex_pkg::OP_MFLO: move_res = lo_fwd_i;
            ex_pkg::OP_MOVZ, ex_pkg::OP_MOVN: move_res = reg1_i;  // condition checked in id
            ex_pkg::OP_SEB: move_res = {{24{reg2_i[7]}}, reg2_i[7:0]};
            ex_pkg::OP_SEH: move_res = {{16{reg2_i[15]}}, reg2_i[15:0]};
            default: move_res = '0;
        endcase
    end

    always_comb begin
        case (alusel_i)
            ex_pkg::SEL_LOGIC: wdata_o = logic_res_i;
            ex_pkg::SEL_SHIFT: wdata_o = shift_res_i;
            ex_pkg::SEL_MOVE:  wdata_o = move_res;
            ex_pkg::SEL_ARITH: wdata_o = arith_res_i;
            ex_pkg::SEL_MUL:   wdata_o = prod_i[ex_pkg::REG_W-1:0];  // mul keeps low word
            ex_pkg::SEL_JUMP:  wdata_o = link_address_i;
            default:           wdata_o = '0;
        endcase
    end

    assign wd_o          = wd_i;
    assign wreg_o        = !rst && wreg_i && !ov_i;   // no write on overflow
    assign except_ov_o   = !rst && ov_i;
    assign except_trap_o = !rst && trap_i;

endmodule

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  ex_pkg::aluop_e               aluop_i,
    input  ex_pkg::alusel_e              alusel_i,
    input  logic [ex_pkg::REG_W-1:0]     reg1_i,
    input  logic [ex_pkg::REG_W-1:0]     reg2_i,
    input  logic [ex_pkg::REGADDR_W-1:0] wd_i,
    input  logic                         wreg_i,
    input  logic [ex_pkg::REG_W-1:0]     link_address_i,
    input  logic [ex_pkg::REG_W-1:0]     hi_i,
    input  logic [ex_pkg::REG_W-1:0]     lo_i,
    input  logic                         mem_whilo_i,
    input  logic [ex_pkg::REG_W-1:0]     mem_hi_i,
    input  logic [ex_pkg::REG_W-1:0]     mem_lo_i,
    input  logic                         wb_whilo_i,
    input  logic [ex_pkg::REG_W-1:0]     wb_hi_i,
    input  logic [ex_pkg::REG_W-1:0]     wb_lo_i,
    output logic [ex_pkg::REGADDR_W-1:0] wd_o,
    output logic                         wreg_o,
    output logic [ex_pkg::REG_W-1:0]     wdata_o,
    output logic                         whilo_o,
    output logic [ex_pkg::REG_W-1:0]     hi_o,
    output logic [ex_pkg::REG_W-1:0]     lo_o,
    output logic                         except_trap_o,
    output logic                         except_ov_o,
    output logic                         stallreq_o
);

    logic [ex_pkg::REG_W-1:0]  logic_res;
    logic [ex_pkg::REG_W-1:0]  shift_res;
    logic [ex_pkg::REG_W-1:0]  arith_res;
    logic                      ov;
    logic                      trap;
    logic [ex_pkg::REG_W-1:0]  hi_fwd;
    logic [ex_pkg::REG_W-1:0]  lo_fwd;
    logic [ex_pkg::DREG_W-1:0] prod;
    logic                      prod_valid;

    ex_alu u_alu (
        .aluop_i     (aluop_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .logic_res_o (logic_res),
        .shift_res_o (shift_res),
        .arith_res_o (arith_res),
        .ov_o        (ov),
        .trap_o      (trap)
    );

    ex_mult u_mult (
        .clk          (clk),
        .rst          (rst),
        .aluop_i      (aluop_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .hi_fwd_i     (hi_fwd),
        .lo_fwd_i     (lo_fwd),
        .prod_o       (prod),
        .prod_valid_o (prod_valid),
        .stallreq_o   (stallreq_o)
    );

    ex_hilo u_hilo (
        .rst          (rst),
        .aluop_i      (aluop_i),
        .reg1_i       (reg1_i),
        .hi_i         (hi_i),
        .lo_i         (lo_i),
        .mem_whilo_i  (mem_whilo_i),
        .mem_hi_i     (mem_hi_i),
        .mem_lo_i     (mem_lo_i),
        .wb_whilo_i   (wb_whilo_i),
        .wb_hi_i      (wb_hi_i),
        .wb_lo_i      (wb_lo_i),
        .prod_i       (prod),
        .prod_valid_i (prod_valid),
        .hi_fwd_o     (hi_fwd),
        .lo_fwd_o     (lo_fwd),
        .whilo_o      (whilo_o),
        .hi_o         (hi_o),
        .lo_o         (lo_o)
    );

    ex_writeback u_writeback (
        .rst            (rst),
        .aluop_i        (aluop_i),
        .alusel_i       (alusel_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .link_address_i (link_address_i),
        .logic_res_i    (logic_res),
        .shift_res_i    (shift_res),
        .arith_res_i    (arith_res),
        .hi_fwd_i       (hi_fwd),
        .lo_fwd_i       (lo_fwd),
        .prod_i         (prod),
        .ov_i           (ov),
        .trap_i         (trap),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o),
        .except_trap_o  (except_trap_o),
        .except_ov_o    (except_ov_o)
    );

endmodule

`default_nettype wire

/* tb_ex_ref.svh */
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

function automatic logic [31:0] ref_logic(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
        ex_pkg::OP_AND: return a & b;
        ex_pkg::OP_OR:  return a | b;
        ex_pkg::OP_XOR: return a ^ b;
        ex_pkg::OP_NOR: return ~(a | b);
        default:        return 32'h0;
    endcase
endfunction

// shift amount from a, data from b
function automatic logic [31:0] ref_shift(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = a[4:0];
    case (op)
        ex_pkg::OP_SLL: return b << sh;
        ex_pkg::OP_SRL: return b >> sh;
        ex_pkg::OP_SRA: return (b >> sh) | (b[31] ? ~(32'hffffffff >> sh) : 32'h0);
        default:        return 32'h0;
    endcase
endfunction

// number of top bits equal to bitval
function automatic logic [31:0] lead_count(logic [31:0] w, logic bitval);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    for (int i = 31; i >= 0; i--) begin
        if (!done && w[i] == bitval) n++;
        else done = 1'b1;
    end
    return 32'(n);
endfunction

function automatic logic [31:0] ref_arith(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
        ex_pkg::OP_ADD, ex_pkg::OP_ADDU: return a + b;
        ex_pkg::OP_SUB, ex_pkg::OP_SUBU: return a - b;
        ex_pkg::OP_SLT:  return {31'h0, $signed(a) < $signed(b)};
        ex_pkg::OP_SLTU: return {31'h0, a < b};
        ex_pkg::OP_CLZ:  return lead_count(a, 1'b0);
        ex_pkg::OP_CLO:  return lead_count(a, 1'b1);
        default:         return 32'h0;
    endcase
endfunction

// 64-bit result out of the 32-bit signed range
function automatic logic ref_ov(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b);
    longint s;
    case (op)
        ex_pkg::OP_ADD: s = longint'($signed(a)) + longint'($signed(b));
        ex_pkg::OP_SUB: s = longint'($signed(a)) - longint'($signed(b));
        default:        s = 0;
    endcase
    return s[32] != s[31];
endfunction

function automatic logic ref_trap(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
        ex_pkg::OP_TEQ:  return a == b;
        ex_pkg::OP_TNE:  return a != b;
        ex_pkg::OP_TGE:  return !($signed(a) < $signed(b));
        ex_pkg::OP_TGEU: return !(a < b);
        ex_pkg::OP_TLT:  return $signed(a) < $signed(b);
        ex_pkg::OP_TLTU: return a < b;
        default:         return 1'b0;
    endcase
endfunction

function automatic logic [31:0] ref_move(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b,
                                         logic [31:0] hi_f, logic [31:0] lo_f);
    case (op)
        ex_pkg::OP_MFHI: return hi_f;
        ex_pkg::OP_MFLO: return lo_f;
        ex_pkg::OP_MOVZ, ex_pkg::OP_MOVN: return a;
        ex_pkg::OP_SEB:  return {{24{b[7]}}, b[7:0]};
        ex_pkg::OP_SEH:  return {{16{b[15]}}, b[15:0]};
        default:         return 32'h0;
    endcase
endfunction

// mem stage first, then wb, then the hi/lo registers
function automatic logic [63:0] ref_fwd(logic mem_we, logic wb_we, logic [31:0] h, logic [31:0] l,
                                        logic [31:0] mh, logic [31:0] ml,
                                        logic [31:0] wh, logic [31:0] wl);
    if (mem_we) return {mh, ml};
    if (wb_we) return {wh, wl};
    return {h, l};
endfunction

function automatic logic [63:0] ref_mul(ex_pkg::aluop_e op, logic [31:0] a, logic [31:0] b,
                                        logic [63:0] acc);
    logic [63:0] p;
    case (op)
        ex_pkg::OP_MULTU, ex_pkg::OP_MADDU, ex_pkg::OP_MSUBU: p = {32'h0, a} * {32'h0, b};
        default: p = longint'($signed(a)) * longint'($signed(b));
    endcase
    case (op)
        ex_pkg::OP_MADD, ex_pkg::OP_MADDU: return acc + p;
        ex_pkg::OP_MSUB, ex_pkg::OP_MSUBU: return acc - p;
        default: return p;
    endcase
endfunction

`endif

/* tb_ex_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;

    logic            clk;
    logic            rst;
    ex_pkg::aluop_e  aluop;
    ex_pkg::alusel_e alusel;
    logic [31:0]     reg1;
    logic [31:0]     reg2;
    logic [4:0]      wd;
    logic            wreg;
    logic [31:0]     link_addr;
    logic [31:0]     hi;
    logic [31:0]     lo;
    logic            mem_whilo;
    logic [31:0]     mem_hi;
    logic [31:0]     mem_lo;
    logic            wb_whilo;
    logic [31:0]     wb_hi;
    logic [31:0]     wb_lo;
    logic [4:0]      wd_o;
    logic            wreg_o;
    logic [31:0]     wdata_o;
    logic            whilo_o;
    logic [31:0]     hi_o;
    logic [31:0]     lo_o;
    logic            except_trap_o;
    logic            except_ov_o;
    logic            stallreq_o;
    integer          seed;
    int              err_cnt;

    `include "tb_ex_ref.svh"

    ex_stage u_dut (
        .clk            (clk),
        .rst            (rst),
        .aluop_i        (aluop),
        .alusel_i       (alusel),
        .reg1_i         (reg1),
        .reg2_i         (reg2),
        .wd_i           (wd),
        .wreg_i         (wreg),
        .link_address_i (link_addr),
        .hi_i           (hi),
        .lo_i           (lo),
        .mem_whilo_i    (mem_whilo),
        .mem_hi_i       (mem_hi),
        .mem_lo_i       (mem_lo),
        .wb_whilo_i     (wb_whilo),
        .wb_hi_i        (wb_hi),
        .wb_lo_i        (wb_lo),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .wdata_o        (wdata_o),
        .whilo_o        (whilo_o),
        .hi_o           (hi_o),
        .lo_o           (lo_o),
        .except_trap_o  (except_trap_o),
        .except_ov_o    (except_ov_o),
        .stallreq_o     (stallreq_o)
    );

    always #10 clk = ~clk;

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic stall_timeout();
        err_cnt++;
        $display("stall request never cleared within 4 cycles at %0t ns", $time);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic set_op(input ex_pkg::aluop_e op, input ex_pkg::alusel_e sel,
                          input logic [31:0] a, input logic [31:0] b);
        aluop     = op;
        alusel    = sel;
        reg1      = a;
        reg2      = b;
        link_addr = $random(seed);
        wd        = link_addr[6:2];
        wreg      = 1'b1;
    endtask

    task automatic randomize_hilo(input logic mem_we, input logic wb_we);
        hi        = $random(seed);
        lo        = $random(seed);
        mem_hi    = $random(seed);
        mem_lo    = $random(seed);
        wb_hi     = $random(seed);
        wb_lo     = $random(seed);
        mem_whilo = mem_we;
        wb_whilo  = wb_we;
    endtask

    task automatic check_reset_quiet();
        assert (!wreg_o && !whilo_o && !stallreq_o && !except_trap_o && !except_ov_o)
            else report_mismatch("an output is active during reset");
    endtask

    task automatic check_simple(input ex_pkg::aluop_e op, input ex_pkg::alusel_e sel,
                                input logic [31:0] a, input logic [31:0] b);
        logic [31:0] exp;
        logic [63:0] fwd;
        logic        ov;
        @(negedge clk);
        set_op(op, sel, a, b);
        #9;   // just ahead of the rising edge
        fwd = ref_fwd(mem_whilo, wb_whilo, hi, lo, mem_hi, mem_lo, wb_hi, wb_lo);
        ov  = ref_ov(op, a, b);
        case (sel)
            ex_pkg::SEL_LOGIC: exp = ref_logic(op, a, b);
            ex_pkg::SEL_SHIFT: exp = ref_shift(op, a, b);
            ex_pkg::SEL_ARITH: exp = ref_arith(op, a, b);
            ex_pkg::SEL_MOVE:  exp = ref_move(op, a, b, fwd[63:32], fwd[31:0]);
            ex_pkg::SEL_JUMP:  exp = link_addr;
            default:           exp = 32'h0;
        endcase
        assert (wdata_o == exp)
            else report_mismatch($sformatf("op %0d wdata %h, expected %h", op, wdata_o, exp));
        assert (wreg_o == !ov)
            else report_mismatch($sformatf("op %0d wreg %b, expected %b", op, wreg_o, !ov));
        assert (except_ov_o == ov)
            else report_mismatch($sformatf("op %0d overflow %b, expected %b", op, except_ov_o, ov));
        assert (wd_o == wd)
            else report_mismatch($sformatf("wd %h, expected %h", wd_o, wd));
    endtask

    task automatic run_class(input ex_pkg::aluop_e op, input ex_pkg::alusel_e sel);
        for (int n = 0; n < 8; n++) begin
            check_simple(op, sel, $random(seed), $random(seed));
        end
    endtask

    task automatic run_trap(input ex_pkg::aluop_e op);
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            a = $random(seed);
            b = (n < 2) ? a : $random(seed);   // a few equal pairs
            set_op(op, ex_pkg::SEL_NOP, a, b);
            #9;
            assert (except_trap_o == ref_trap(op, a, b))
                else report_mismatch($sformatf("op %0d trap %b for %h, %h", op,
                                               except_trap_o, a, b));
        end
    endtask

    task automatic check_fwd(input ex_pkg::aluop_e op, input logic mem_we, input logic wb_we);
        logic [63:0] fwd;
        @(negedge clk);
        randomize_hilo(mem_we, wb_we);
        set_op(op, ex_pkg::SEL_MOVE, $random(seed), $random(seed));
        #9;
        fwd = ref_fwd(mem_whilo, wb_whilo, hi, lo, mem_hi, mem_lo, wb_hi, wb_lo);
        case (op)
            ex_pkg::OP_MFHI: assert (wdata_o == fwd[63:32])
                else report_mismatch($sformatf("mfhi %h, expected %h", wdata_o, fwd[63:32]));
            ex_pkg::OP_MFLO: assert (wdata_o == fwd[31:0])
                else report_mismatch($sformatf("mflo %h, expected %h", wdata_o, fwd[31:0]));
            ex_pkg::OP_MTHI: assert (whilo_o && hi_o == reg1 && lo_o == fwd[31:0])
                else report_mismatch($sformatf("mthi gives %b %h %h", whilo_o, hi_o, lo_o));
            default: assert (whilo_o && hi_o == fwd[63:32] && lo_o == reg1)
                else report_mismatch($sformatf("mtlo gives %b %h %h", whilo_o, hi_o, lo_o));
        endcase
    endtask

    task automatic check_mul(input ex_pkg::aluop_e op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] exp;
        logic [31:0] flags;
        int          cycles;
        @(negedge clk);
        flags = $random(seed);
        randomize_hilo(flags[0], flags[1]);
        set_op(op, (op == ex_pkg::OP_MUL) ? ex_pkg::SEL_MUL : ex_pkg::SEL_NOP, a, b);
        #9;
        assert (stallreq_o && !whilo_o)
            else report_mismatch($sformatf("op %0d first cycle stall %b whilo %b", op,
                                           stallreq_o, whilo_o));
        cycles = 0;
        // inputs stay put while stalled
        while (stallreq_o && cycles < 4) begin
            @(negedge clk);
            #9;
            cycles++;
        end
        if (stallreq_o) stall_timeout();
        assert (cycles == 1)
            else report_mismatch($sformatf("op %0d stalled %0d cycles, expected 1", op, cycles));
        exp = ref_mul(op, a, b, ref_fwd(mem_whilo, wb_whilo, hi, lo, mem_hi, mem_lo, wb_hi, wb_lo));
        if (op == ex_pkg::OP_MUL) begin
            assert (wdata_o == exp[31:0] && !whilo_o)
                else report_mismatch($sformatf("mul wdata %h whilo %b, expected %h", wdata_o,
                                               whilo_o, exp[31:0]));
        end else begin
            assert (whilo_o && {hi_o, lo_o} == exp)
                else report_mismatch($sformatf("op %0d hi/lo %h%h, expected %h", op, hi_o,
                                               lo_o, exp));
        end
    endtask

    initial begin
        seed    = 71;
        err_cnt = 0;
        clk     = 1'b0;
        rst     = 1'b1;
        set_op(ex_pkg::OP_NOP, ex_pkg::SEL_NOP, 32'h0, 32'h0);
        randomize_hilo(1'b0, 1'b0);

        // busy inputs under reset, outputs must stay quiet
        for (int i = 0; i < 15; i++) begin
            @(negedge clk);
            case (i % 4)
                0: set_op(ex_pkg::OP_MULT, ex_pkg::SEL_NOP, 32'h5, 32'h7);
                1: set_op(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, 32'h7fffffff, 32'h1);
                2: set_op(ex_pkg::OP_TEQ, ex_pkg::SEL_NOP, 32'h9, 32'h9);
                default: set_op(ex_pkg::OP_MTHI, ex_pkg::SEL_NOP, 32'h3, 32'h0);
            endcase
            #9;
            check_reset_quiet();
        end
        @(negedge clk);
        rst = 1'b0;
        set_op(ex_pkg::OP_NOP, ex_pkg::SEL_NOP, 32'h0, 32'h0);

        run_class(ex_pkg::OP_AND, ex_pkg::SEL_LOGIC);
        run_class(ex_pkg::OP_OR, ex_pkg::SEL_LOGIC);
        run_class(ex_pkg::OP_XOR, ex_pkg::SEL_LOGIC);
        run_class(ex_pkg::OP_NOR, ex_pkg::SEL_LOGIC);
        run_class(ex_pkg::OP_SLL, ex_pkg::SEL_SHIFT);
        run_class(ex_pkg::OP_SRL, ex_pkg::SEL_SHIFT);
        run_class(ex_pkg::OP_SRA, ex_pkg::SEL_SHIFT);
        run_class(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_ADDU, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_SUBU, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_SLT, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_SLTU, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_CLZ, ex_pkg::SEL_ARITH);
        run_class(ex_pkg::OP_CLO, ex_pkg::SEL_ARITH);
        check_simple(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, 32'h7fffffff, 32'h00000001);
        check_simple(ex_pkg::OP_ADD, ex_pkg::SEL_ARITH, 32'h80000000, 32'h80000000);
        check_simple(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH, 32'h80000000, 32'h00000001);
        check_simple(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH, 32'h7fffffff, 32'hffffffff);
        // most negative subtrahend
        check_simple(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH, 32'h00000005, 32'h80000000);
        check_simple(ex_pkg::OP_SUB, ex_pkg::SEL_ARITH, 32'hffffffff, 32'h80000000);
        check_simple(ex_pkg::OP_CLZ, ex_pkg::SEL_ARITH, 32'h00000000, 32'h0);
        check_simple(ex_pkg::OP_CLZ, ex_pkg::SEL_ARITH, 32'h00010000, 32'h0);
        check_simple(ex_pkg::OP_CLO, ex_pkg::SEL_ARITH, 32'hffffffff, 32'h0);
        check_simple(ex_pkg::OP_CLO, ex_pkg::SEL_ARITH, 32'hff00ffff, 32'h0);

        run_trap(ex_pkg::OP_TEQ);
        run_trap(ex_pkg::OP_TNE);
        run_trap(ex_pkg::OP_TGE);
        run_trap(ex_pkg::OP_TGEU);
        run_trap(ex_pkg::OP_TLT);
        run_trap(ex_pkg::OP_TLTU);

        for (int m = 0; m < 2; m++) begin
            for (int w = 0; w < 2; w++) begin
                check_fwd(ex_pkg::OP_MFHI, m[0], w[0]);
                check_fwd(ex_pkg::OP_MFLO, m[0], w[0]);
                check_fwd(ex_pkg::OP_MTHI, m[0], w[0]);
                check_fwd(ex_pkg::OP_MTLO, m[0], w[0]);
            end
        end

        for (int n = 0; n < 4; n++) begin
            check_mul(ex_pkg::OP_MULT, $random(seed), $random(seed));
            check_mul(ex_pkg::OP_MULTU, $random(seed), $random(seed));
            check_mul(ex_pkg::OP_MUL, $random(seed), $random(seed));
            check_mul(ex_pkg::OP_MADD, $random(seed), $random(seed));
            check_mul(ex_pkg::OP_MADDU, $random(seed), $random(seed));
            check_mul(ex_pkg::OP_MSUB, $random(seed), $random(seed));
            check_mul(ex_pkg::OP_MSUBU, $random(seed), $random(seed));
        end
        check_mul(ex_pkg::OP_MULTU, 32'hffffffff, 32'hffffffff);
        check_mul(ex_pkg::OP_MULT, 32'h80000000, 32'h80000000);

        run_class(ex_pkg::OP_MOVZ, ex_pkg::SEL_MOVE);
        run_class(ex_pkg::OP_MOVN, ex_pkg::SEL_MOVE);
        run_class(ex_pkg::OP_SEB, ex_pkg::SEL_MOVE);
        run_class(ex_pkg::OP_SEH, ex_pkg::SEL_MOVE);
        run_class(ex_pkg::OP_NOP, ex_pkg::SEL_JUMP);

        if (err_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* ex_stage.f */
+incdir+.
ex_pkg.sv
ex_count_lead.sv
ex_alu.sv
ex_mult.sv
ex_hilo.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv
